// File: sprite_rom.mem
// four 8x8 sprites, one texel row per line, one hex palette index per column
// blocks in order face_down, face_right, face_up, face_left, index 0 is see-through
// face_down
0 0 5 5 5 5 0 0
0 5 4 4 4 4 5 0
0 3 6 3 3 6 3 0
0 3 7 3 3 7 3 0
0 8 8 8 8 8 8 0
3 8 8 8 8 8 8 3
0 c c 0 0 c c 0
0 7 7 0 0 7 7 0
// face_right
0 0 5 5 5 5 0 0
0 5 4 4 4 3 0 0
0 5 4 3 6 3 0 0
0 0 3 3 7 3 3 0
0 0 8 8 8 8 0 0
0 0 8 8 3 8 0 0
0 0 c c c c 0 0
0 0 7 7 0 7 7 0
// face_up
0 0 5 5 5 5 0 0
0 5 4 4 4 4 5 0
0 5 4 4 4 4 5 0
0 0 5 4 4 5 0 0
0 8 8 8 8 8 8 0
3 8 8 8 8 8 8 3
0 c c 0 0 c c 0
0 7 7 0 0 7 7 0
// face_left
0 0 5 5 5 5 0 0
0 0 3 4 4 4 5 0
0 0 3 6 3 4 5 0
0 3 3 7 3 3 0 0
0 0 8 8 8 8 0 0
0 0 8 3 8 8 0 0
0 0 c c c c 0 0
0 7 7 0 7 7 0 0

// File: background_map.mem
// 16x12 tile map, one row of tiles per line (y/40)
// one hex bg_palette index per column (x/40)
1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1
1 0 0 0 0 b 0 0 0 0 0 0 a 0 0 1
1 0 a 0 0 0 0 2 2 0 0 0 0 0 0 1
1 0 0 0 0 0 0 2 2 0 0 4 4 4 0 1
1 0 0 8 9 0 0 2 2 0 4 5 5 4 0 1
1 0 0 9 8 0 0 2 2 0 4 5 5 4 0 1
1 2 2 2 2 2 2 3 3 2 2 2 2 2 2 1
1 0 0 0 0 0 0 2 2 0 0 0 0 0 0 1
1 0 6 7 6 0 0 2 2 0 0 c 0 0 0 1
1 0 7 7 7 0 0 2 2 0 0 0 0 b 0 1
1 0 0 0 0 0 0 2 2 0 0 0 a 0 0 1
1 1 1 1 1 1 1 e e 1 1 1 1 1 1 1

// File: sim.f
hw/sprite_pkg.sv
hw/vga_timing.sv
hw/sprite_addr_stage.sv
hw/tile_fetch_stage.sv
hw/pixel_compose_stage.sv
hw/sprite_display_top.sv
verif/tb_clock_gen.sv
verif/tb_sprite_display.sv

// File: Bender.yml
package:
  name: vga_sprite_display

sources:
  - files:
      - hw/sprite_pkg.sv
      - hw/vga_timing.sv
      - hw/sprite_addr_stage.sv
      - hw/tile_fetch_stage.sv
      - hw/pixel_compose_stage.sv
      - hw/sprite_display_top.sv
  - target: simulation
    files:
      - verif/tb_clock_gen.sv
      - verif/tb_sprite_display.sv

// File: verif/tb_sprite_display.sv
`timescale 1ns/1ps

module tb_sprite_display
	import sprite_pkg::*;
();

	localparam integer frame_cycles   = h_total * v_total;
	localparam integer run_pixels     = 2 * frame_cycles;            // two full frames
	localparam integer reset_cycles   = 16;
	localparam integer timeout_cycles = run_pixels + reset_cycles + 1000; // 841016

	typedef struct packed {
		rgb_t       colour;
		logic       hsync;
		logic       vsync;
		logic [1:0] kind;  // 0 reset, 1 blanking, 2 background, 3 sprite
		logic [9:0] pos_x;
		logic [9:0] pos_y;
	} expect_t;

	logic       vga_clk;
	logic       arst_n;
	logic [7:0] keycode;
	logic [9:0] sprite_x;
	logic [9:0] sprite_y;
	rgb_t       rgb;
	logic       hsync;
	logic       vsync;

	logic [3:0] ref_spr [0:255];
	logic [3:0] ref_map [0:191];
	expect_t    pipe_q [$];    // predictions waiting out the latency
	integer     seed;
	integer     mx;
	integer     my;
	integer     lat_x;
	integer     lat_y;
	facing_e    model_facing;
	integer     n_checked;
	integer     cycle_count;

	tb_clock_gen u_clk_gen (
		.vga_clk (vga_clk),
		.arst_n  (arst_n)
	);

	sprite_display_top u_dut (
		.vga_clk  (vga_clk),
		.arst_n   (arst_n),
		.keycode  (keycode),
		.sprite_x (sprite_x),
		.sprite_y (sprite_y),
		.rgb      (rgb),
		.hsync    (hsync),
		.vsync    (vsync)
	);

	////////////////////
	// reference model
	////////////////////
	function automatic facing_e decode_key(input logic [7:0] key, input facing_e prev);
		case (key)
			8'h07:   return face_right;
			8'h1A:   return face_up;
			8'h04:   return face_left;
			8'h16:   return face_down;
			default: return prev; // unknown key
		endcase
	endfunction

	function automatic expect_t predict_pixel(input integer x, input integer y);
		expect_t    e;
		integer     sx;
		integer     sy;
		logic [3:0] idx;
		e.pos_x  = 10'(x);
		e.pos_y  = 10'(y);
		e.hsync  = !((x >= 656) && (x < 752));
		e.vsync  = !((y >= 490) && (y < 492));
		e.colour = '0;
		e.kind   = 2'd1;
		if ((x < 640) && (y < 480))
		begin
			sx       = x - lat_x;
			sy       = y - lat_y;
			e.kind   = 2'd2;
			e.colour = bg_palette[ref_map[(x / 40) + (y / 40) * 16]];
			if ((sx >= 0) && (sx < 32) && (sy >= 0) && (sy < 32))
			begin
				idx = ref_spr[int'(model_facing) * 64 + (sy / 4) * 8 + sx / 4];
				if (idx != 4'd0)
				begin
					e.colour = spr_palette[idx];
					e.kind   = 2'd3;
				end
			end
		end
		return e;
	endfunction

	function automatic string test_name(input expect_t e);
		string kind_s;
		case (e.kind)
			2'd0:    kind_s = "reset";
			2'd1:    kind_s = "blanking";
			2'd2:    kind_s = "background";
			default: kind_s = "sprite";
		endcase
		return $sformatf("%s x=%0d y=%0d", kind_s, e.pos_x, e.pos_y);
	endfunction

	////////////////////
	// compare tasks
	////////////////////
	task automatic check_rgb(input string name, input rgb_t exp, input rgb_t act);
		if (act !== exp)
		begin
			$display("CHECK FAILED: %s rgb expected %h actual %h", name, exp, act);
			$display("TEST RESULT: FAIL");
			$fatal(1, "colour output mismatch");
		end
	endtask

	// pair is {hsync, vsync}
	task automatic check_sync(input string name, input logic [1:0] exp, input logic [1:0] act);
		if (act !== exp)
		begin
			$display("CHECK FAILED: %s sync expected %b actual %b", name, exp, act);
			$display("TEST RESULT: FAIL");
			$fatal(1, "sync output mismatch");
		end
	endtask

	////////////////////
	// stimulus
	////////////////////
	always @(posedge vga_clk)
	begin : drive_inputs
		integer pick;
		pick = $unsigned($random(seed)) % 8;
		case (pick)
			0:       keycode <= 8'h07;
			1:       keycode <= 8'h1A;
			2:       keycode <= 8'h04;
			3:       keycode <= 8'h16;
			default: keycode <= 8'($random(seed)); // mostly unknown keys
		endcase
		sprite_x <= 10'($unsigned($random(seed)) % 640);
		sprite_y <= 10'($unsigned($random(seed)) % 480);
	end

	// outputs and inputs are both settled at the falling edge
	always @(negedge vga_clk)
	begin : model_step
		expect_t now_e;
		expect_t due;
		if (!arst_n)
		begin
			check_rgb("reset", '0, rgb);
			check_sync("reset", 2'b11, {hsync, vsync});
		end
		else
		begin
			if ((mx == 0) && (my == 0))
			begin
				lat_x        = sprite_x; // frame latch
				lat_y        = sprite_y;
				model_facing = decode_key(keycode, model_facing);
			end
			now_e = predict_pixel(mx, my);
			pipe_q.push_back(now_e);
			due = pipe_q.pop_front();
			check_rgb(test_name(due), due.colour, rgb);
			check_sync(test_name(due), {due.hsync, due.vsync}, {hsync, vsync});
			n_checked = n_checked + 1;
			mx = mx + 1;
			if (mx == h_total)
			begin
				mx = 0;
				my = (my == v_total - 1) ? 0 : my + 1;
			end
		end
	end

	always @(posedge vga_clk)
	begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= timeout_cycles)
		begin
			$display("timeout: raster not fully checked after %0d cycles", timeout_cycles);
			$display("TEST RESULT: FAIL");
			$fatal(1, "timeout");
		end
	end

	initial
	begin
		expect_t rst_e;
		seed         = 32'hd1ca;
		keycode      = 8'h00;
		sprite_x     = '0;
		sprite_y     = '0;
		mx           = 0;
		my           = 0;
		lat_x        = 0;
		lat_y        = 0;
		model_facing = face_down;
		n_checked    = 0;
		cycle_count  = 0;
		$readmemh("sprite_rom.mem", ref_spr);
		$readmemh("background_map.mem", ref_map);
		rst_e = '{colour: '0, hsync: 1'b1, vsync: 1'b1, kind: 2'd0, pos_x: '0, pos_y: '0};
		repeat (pipe_lat)
			pipe_q.push_back(rst_e); // output still shows reset values
		while (n_checked < run_pixels + pipe_lat)
			@(posedge vga_clk);
		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

// File: verif/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen
(
	output logic vga_clk,
	output logic arst_n
);

	initial
	begin
		vga_clk = 1'b0;
		forever
			#50 vga_clk = ~vga_clk; // 100 ns period
	end

	initial
	begin
		arst_n = 1'b0;
		repeat (16)
			@(posedge vga_clk);
		#25 arst_n = 1'b1; // released mid high phase, away from both edges
	end

endmodule

// File: hw/sprite_display_top.sv
`timescale 1ns/1ps

module sprite_display_top
	import sprite_pkg::*;
(
	input  logic       vga_clk,
	input  logic       arst_n,
	input  logic [7:0] keycode,
	input  logic [9:0] sprite_x,
	input  logic [9:0] sprite_y,
	output rgb_t       rgb,
	output logic       hsync,
	output logic       vsync
);

	pix_t   pix;   // counter stage out
	addr_t  addr;  // address stage out
	fetch_t fetch; // rom stage out

	vga_timing u_timing (
		.vga_clk (vga_clk),
		.arst_n  (arst_n),
		.pix     (pix)
	);

	sprite_addr_stage u_addr (
		.vga_clk  (vga_clk),
		.arst_n   (arst_n),
		.pix      (pix),
		.keycode  (keycode),
		.sprite_x (sprite_x),
		.sprite_y (sprite_y),
		.addr     (addr)
	);

	tile_fetch_stage u_fetch (
		.vga_clk (vga_clk),
		.addr    (addr),
		.fetch   (fetch)
	);

	pixel_compose_stage u_compose (
		.vga_clk (vga_clk),
		.arst_n  (arst_n),
		.fetch   (fetch),
		.rgb     (rgb),
		.hsync   (hsync),
		.vsync   (vsync)
	);

endmodule

// File: hw/pixel_compose_stage.sv
`timescale 1ns/1ps

module pixel_compose_stage
	import sprite_pkg::*;
(
	input  logic   vga_clk,
	input  logic   arst_n,
	input  fetch_t fetch,
	output rgb_t   rgb,
	output logic   hsync,
	output logic   vsync
);

	rgb_t spr_col;
	rgb_t bg_col;
	rgb_t colour_c;

	assign spr_col = spr_palette[fetch.spr_idx];
	assign bg_col  = bg_palette[fetch.bg_idx];

	////////////////////
	// layer select
	////////////////////
	always_comb
	begin
		if (!fetch.active)
			colour_c = '0; // blanking
		else if (fetch.spr_hit && (fetch.spr_idx != 4'd0))
			colour_c = spr_col;
		else
			colour_c = bg_col; // also shows through index 0
	end

	always_ff @(posedge vga_clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			rgb   <= '0;
			hsync <= 1'b1;
			vsync <= 1'b1;
		end
		else
		begin
			rgb   <= colour_c;
			hsync <= fetch.hsync;
			vsync <= fetch.vsync;
		end
	end

	a_blank_black: assert property (@(posedge vga_clk) disable iff (!arst_n)
		!fetch.active |=> (rgb == '0));

endmodule

// File: hw/tile_fetch_stage.sv
`timescale 1ns/1ps

module tile_fetch_stage
	import sprite_pkg::*;
(
	input  logic   vga_clk,
	input  addr_t  addr,
	output fetch_t fetch
);

	////////////////////
	// rom contents
	////////////////////
	logic [3:0] spr_rom [0:4*spr_dim*spr_dim-1]; // four facings of 64 texels
	logic [3:0] map_rom [0:map_w*map_h-1];       // 192 tile indices

	initial
	begin
		$readmemh("sprite_rom.mem", spr_rom);
		$readmemh("background_map.mem", map_rom);
	end

	// synchronous reads, flags ride along
	always_ff @(posedge vga_clk)
	begin
		fetch.spr_idx <= spr_rom[addr.spr_addr];
		fetch.bg_idx  <= map_rom[addr.map_addr];
		fetch.spr_hit <= addr.spr_hit;
		fetch.active  <= addr.active;
		fetch.hsync   <= addr.hsync;
		fetch.vsync   <= addr.vsync;
	end

endmodule

// File: hw/sprite_addr_stage.sv
`timescale 1ns/1ps

module sprite_addr_stage
	import sprite_pkg::*;
(
	input  logic       vga_clk,
	input  logic       arst_n,
	input  pix_t       pix,
	input  logic [7:0] keycode,
	input  logic [9:0] sprite_x,
	input  logic [9:0] sprite_y,
	output addr_t      addr
);

	logic [9:0] lat_x;
	logic [9:0] lat_y;
	facing_e    facing;
	facing_e    face_nxt;
	facing_e    face_use;
	logic       frame_start;
	logic [9:0] pos_x;
	logic [9:0] pos_y;
	logic [9:0] dx;
	logic [9:0] dy;
	logic       hit;
	logic [7:0] spr_addr_c;
	logic [7:0] map_addr_c;

	assign frame_start = (pix.x == '0) && (pix.y == '0);

	always_comb
	begin
		case (keycode)
			8'h07:   face_nxt = face_right;
			8'h1A:   face_nxt = face_up;
			8'h04:   face_nxt = face_left;
			8'h16:   face_nxt = face_down;
			default: face_nxt = facing; // unknown key keeps facing
		endcase
	end

	// first pixel already uses the freshly sampled values
	assign pos_x    = frame_start ? sprite_x : lat_x;
	assign pos_y    = frame_start ? sprite_y : lat_y;
	assign face_use = frame_start ? face_nxt : facing;

	////////////////////
	// hit test
	////////////////////
	assign dx  = pix.x - pos_x;
	assign dy  = pix.y - pos_y;
	assign hit = (pix.x >= pos_x) && (dx < 10'(spr_px)) &&
	             (pix.y >= pos_y) && (dy < 10'(spr_px)); // no wrap once x >= pos

	assign spr_addr_c = 8'(face_use) * 8'(spr_dim * spr_dim)
	                  + 8'((dy / spr_scale) * spr_dim)
	                  + 8'(dx / spr_scale);

	// off-screen coords would run past the map
	assign map_addr_c = pix.active ? 8'(pix.x / tile_px + (pix.y / tile_px) * map_w) : '0;

	always_ff @(posedge vga_clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			lat_x  <= '0;
			lat_y  <= '0;
			facing <= face_down;
			addr   <= '{spr_addr: '0, spr_hit: 1'b0, map_addr: '0,
			            active: 1'b0, hsync: 1'b1, vsync: 1'b1};
		end
		else
		begin
			if (frame_start)
			begin
				lat_x  <= sprite_x; // once per frame
				lat_y  <= sprite_y;
				facing <= face_nxt;
			end
			addr.spr_addr <= spr_addr_c;
			addr.spr_hit  <= hit;
			addr.map_addr <= map_addr_c;
			addr.active   <= pix.active;
			addr.hsync    <= pix.hsync;
			addr.vsync    <= pix.vsync;
		end
	end

	// a hit never reads another facing's bank
	a_spr_bank: assert property (@(posedge vga_clk) disable iff (!arst_n)
		addr.spr_hit |-> (facing_e'(addr.spr_addr[7:6]) == facing));

endmodule

// File: hw/vga_timing.sv
`timescale 1ns/1ps

module vga_timing
	import sprite_pkg::*;
(
	input  logic vga_clk,
	input  logic arst_n,
	output pix_t pix
);

	logic [9:0] nxt_x;
	logic [9:0] nxt_y;

	////////////////////
	// wrapping counters
	////////////////////
	always_comb
	begin
		nxt_x = pix.x + 10'd1;
		nxt_y = pix.y;
		if (pix.x == 10'(h_total - 1))
		begin
			nxt_x = '0; // end of line
			if (pix.y == 10'(v_total - 1))
				nxt_y = '0; // end of frame
			else
				nxt_y = pix.y + 10'd1;
		end
	end

	// flags decoded from the next position so they line up with x and y
	always_ff @(posedge vga_clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			pix <= '{x: '0, y: '0, active: 1'b1, hsync: 1'b1, vsync: 1'b1};
		end
		else
		begin
			pix.x      <= nxt_x;
			pix.y      <= nxt_y;
			pix.active <= (nxt_x < 10'(h_active)) && (nxt_y < 10'(v_active));
			pix.hsync  <= !((nxt_x >= 10'(h_active + h_front)) &&
			               (nxt_x < 10'(h_active + h_front + h_sync))); // low 656..751
			pix.vsync  <= !((nxt_y >= 10'(v_active + v_front)) &&
			               (nxt_y < 10'(v_active + v_front + v_sync))); // low 490..491
		end
	end

	a_counter_range: assert property (@(posedge vga_clk) disable iff (!arst_n)
		(pix.x < 10'(h_total)) && (pix.y < 10'(v_total)));

endmodule

// File: hw/sprite_pkg.sv
package sprite_pkg;

	////////////////////
	// raster timing
	////////////////////
	localparam integer h_active = 640;
	localparam integer h_front  = 16;
	localparam integer h_sync   = 96;
	localparam integer h_back   = 48;
	localparam integer h_total  = h_active + h_front + h_sync + h_back; // 800

	localparam integer v_active = 480;
	localparam integer v_front  = 10;
	localparam integer v_sync   = 2;
	localparam integer v_back   = 33;
	localparam integer v_total  = v_active + v_front + v_sync + v_back; // 525

	////////////////////
	// tiles and sprite
	////////////////////
	localparam integer tile_px   = 40; // square tile edge
	localparam integer map_w     = 16;
	localparam integer map_h     = 12;
	localparam integer spr_dim   = 8;  // texels per side
	localparam integer spr_scale = 4;  // pixels per texel
	localparam integer spr_px    = spr_dim * spr_scale;
	localparam integer pipe_lat  = 3;  // counter to colour output

	// bank select in the sprite rom
	typedef enum logic [1:0] {
		face_down  = 2'd0,
		face_right = 2'd1,
		face_up    = 2'd2,
		face_left  = 2'd3
	} facing_e;

	typedef struct packed {
		logic [3:0] red;
		logic [3:0] green;
		logic [3:0] blue;
	} rgb_t;

	typedef struct packed {
		logic [9:0] x;
		logic [9:0] y;
		logic       active;
		logic       hsync; // active low
		logic       vsync; // active low
	} pix_t;

	typedef struct packed {
		logic [7:0] spr_addr;
		logic       spr_hit;
		logic [7:0] map_addr;
		logic       active;
		logic       hsync;
		logic       vsync;
	} addr_t;

	typedef struct packed {
		logic [3:0] spr_idx;
		logic       spr_hit;
		logic [3:0] bg_idx;
		logic       active;
		logic       hsync;
		logic       vsync;
	} fetch_t;

	////////////////////
	// palettes
	////////////////////
	// entry 0 is never shown, index 0 means see-through
	localparam rgb_t spr_palette [16] = '{
		12'h000, 12'h2a2, 12'h1f1, 12'hfc9,
		12'hb62, 12'h731, 12'hfff, 12'h222,
		12'hd22, 12'hf80, 12'hff4, 12'h48f,
		12'h24a, 12'hccc, 12'h888, 12'hf6c
	};

	localparam rgb_t bg_palette [16] = '{
		12'h3a3, 12'h282, 12'hdc8, 12'hba6,
		12'h36c, 12'h25a, 12'h777, 12'h555,
		12'h642, 12'h431, 12'h161, 12'h9d9,
		12'hcb9, 12'h8ae, 12'h333, 12'heee
	};

endpackage
